//--- hdl/ctn_arbiter.sv
/*
  Two-host round-robin socket. Grant is decided in the same cycle and the
  winner is registered onto the downstream bus; responses are steered by id.
*/
module ctn_arbiter (
  input  logic                  clk_aon,
  input  logic                  rst_n_i,

  ctn_bus_if.fabric             hosts [ctn_bus_pkg::NumHosts],
  ctn_bus_if.host               down,
  output ctn_bus_pkg::host_id_t down_id_o,
  input  ctn_bus_pkg::host_id_t rsp_id_i
);

  logic [ctn_bus_pkg::NumHosts-1:0] valid;
  logic [ctn_bus_pkg::NumHosts-1:0] ready;
  logic [ctn_bus_pkg::NumHosts-1:0] h_we;
  ctn_bus_pkg::addr_t [ctn_bus_pkg::NumHosts-1:0] h_addr;
  ctn_bus_pkg::data_t [ctn_bus_pkg::NumHosts-1:0] h_wdata;
  ctn_bus_pkg::strb_t [ctn_bus_pkg::NumHosts-1:0] h_strb;

  ctn_bus_pkg::arb_state_e last_q;
  ctn_bus_pkg::host_id_t   gnt_id;
  logic                    load_en;
  logic                    down_valid_q;

  //////////////////////////////////////////////////////////////////////
  // Per-host unpacking and response steering
  //////////////////////////////////////////////////////////////////////

  for (genvar h = 0; h < ctn_bus_pkg::NumHosts; h++) begin : g_host
    assign valid[h]   = hosts[h].req_valid;
    assign h_we[h]    = hosts[h].we;
    assign h_addr[h]  = hosts[h].addr;
    assign h_wdata[h] = hosts[h].wdata;
    assign h_strb[h]  = hosts[h].strb;

    assign ready[h]           = load_en && (gnt_id == ctn_bus_pkg::host_id_t'(h)) && valid[h];
    assign hosts[h].req_ready = ready[h];

    assign hosts[h].rsp_valid = down.rsp_valid && (rsp_id_i == ctn_bus_pkg::host_id_t'(h));
    assign hosts[h].rsp_rdata = down.rsp_rdata;  // Qualified by rsp_valid
    assign hosts[h].rsp_err   = down.rsp_err;
  end

  //////////////////////////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////////////////////////

  // Output register free or draining this cycle
  assign load_en = !down_valid_q || down.req_ready;

  always_comb begin
    gnt_id = '0;
    if (valid[0] && valid[1]) begin
      // Both asking, the one not served last wins
      gnt_id = (last_q == ctn_bus_pkg::LAST_H0) ? 1'b1 : 1'b0;
    end else if (valid[1]) begin
      gnt_id = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registered winner
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      down_valid_q <= 1'b0;
      last_q       <= ctn_bus_pkg::LAST_H1;
    end else if (load_en) begin
      down_valid_q <= |valid;
      if (|valid) begin
        last_q <= ctn_bus_pkg::arb_state_e'(gnt_id);
      end
    end
  end

  always_ff @(posedge clk_aon) begin
    if (load_en && |valid) begin
      down.we    <= h_we[gnt_id];
      down.addr  <= h_addr[gnt_id];
      down.wdata <= h_wdata[gnt_id];
      down.strb  <= h_strb[gnt_id];
      down_id_o  <= gnt_id;
    end
  end

  assign down.req_valid = down_valid_q;

  a_one_ready : assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    $onehot0(ready));

endmodule : ctn_arbiter

//--- hdl/ctn_bus_if.sv
/*
  One request channel with valid/ready and its response strobe.
  The response has no ready, so the receiver must sink it in that cycle.
*/
interface ctn_bus_if;

  // Request
  logic                req_valid;
  logic                req_ready;
  logic                we;
  ctn_bus_pkg::addr_t  addr;
  ctn_bus_pkg::data_t  wdata;
  ctn_bus_pkg::strb_t  strb;

  // Response, one cycle per request
  logic                rsp_valid;
  ctn_bus_pkg::data_t  rsp_rdata;
  logic                rsp_err;

  modport host (
    output req_valid,
    output we,
    output addr,
    output wdata,
    output strb,
    input  req_ready,
    input  rsp_valid,
    input  rsp_rdata,
    input  rsp_err
  );

  modport fabric (
    input  req_valid,
    input  we,
    input  addr,
    input  wdata,
    input  strb,
    output req_ready,
    output rsp_valid,
    output rsp_rdata,
    output rsp_err
  );

endinterface : ctn_bus_if

//--- hdl/ctn_bus_pkg.sv
/*
  Bus-level types for the CTN memory path. Two hosts only; the arbiter's
  round-robin state below has no encoding for a third host.
*/
package ctn_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Fabric size
  //////////////////////////////////////////////////////////////////////

  parameter int NumHosts = 2;

  //////////////////////////////////////////////////////////////////////
  // Bus fields
  //////////////////////////////////////////////////////////////////////

  parameter int AddrWidth = 32;
  parameter int DataWidth = 32;
  parameter int StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;  // Byte address
  typedef logic [DataWidth-1:0] data_t;  // One bus word
  typedef logic [StrbWidth-1:0] strb_t;  // One bit per byte lane

  // Index of the issuing host, travels beside the request and response
  typedef logic [$clog2(NumHosts)-1:0] host_id_t;

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  // Host served on the last grant
  typedef enum logic {
    LAST_H0 = 1'b0,
    LAST_H1 = 1'b1
  } arb_state_e;

endpackage : ctn_bus_pkg

//--- hdl/ctn_fabric_top.sv
/*
  Two hosts sharing one RAM through a round-robin socket and window decoder.
  Fixed three-cycle request-to-response latency, errors outside the window.
*/
module ctn_fabric_top #(
  parameter int MaxOutstanding = 2,
  parameter int Latency        = ctn_mem_pkg::RamLatency
) (
  input  logic                                          clk_aon,
  input  logic                                          rst_n_i,

  input  logic [ctn_bus_pkg::NumHosts-1:0]               host_req_valid_i,
  input  logic [ctn_bus_pkg::NumHosts-1:0]               host_we_i,
  input  ctn_bus_pkg::addr_t [ctn_bus_pkg::NumHosts-1:0] host_addr_i,
  input  ctn_bus_pkg::data_t [ctn_bus_pkg::NumHosts-1:0] host_wdata_i,
  input  ctn_bus_pkg::strb_t [ctn_bus_pkg::NumHosts-1:0] host_strb_i,
  output logic [ctn_bus_pkg::NumHosts-1:0]               host_req_ready_o,
  output logic [ctn_bus_pkg::NumHosts-1:0]               host_rsp_valid_o,
  output ctn_bus_pkg::data_t [ctn_bus_pkg::NumHosts-1:0] host_rsp_rdata_o,
  output logic [ctn_bus_pkg::NumHosts-1:0]               host_rsp_err_o
);

  ctn_bus_if bus_h [ctn_bus_pkg::NumHosts] ();
  ctn_bus_if bus_d ();

  ctn_bus_pkg::host_id_t   down_id;
  ctn_bus_pkg::host_id_t   rsp_id;

  logic                    ram_req;
  logic                    ram_we;
  ctn_mem_pkg::word_addr_t ram_addr;
  ctn_bus_pkg::data_t      ram_wdata;
  ctn_bus_pkg::strb_t      ram_strb;
  ctn_bus_pkg::data_t      ram_rdata;

  //////////////////////////////////////////////////////////////////////
  // Host ports
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < ctn_bus_pkg::NumHosts; g++) begin : g_port
    ctn_host_port #(
      .MaxOutstanding(MaxOutstanding)
    ) u_host_port (
      .clk_aon     (clk_aon),
      .rst_n_i     (rst_n_i),
      .req_valid_i (host_req_valid_i[g]),
      .we_i        (host_we_i[g]),
      .addr_i      (host_addr_i[g]),
      .wdata_i     (host_wdata_i[g]),
      .strb_i      (host_strb_i[g]),
      .req_ready_o (host_req_ready_o[g]),
      .rsp_valid_o (host_rsp_valid_o[g]),
      .rsp_rdata_o (host_rsp_rdata_o[g]),
      .rsp_err_o   (host_rsp_err_o[g]),
      .bus         (bus_h[g])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Socket, decoder and RAM
  //////////////////////////////////////////////////////////////////////

  ctn_arbiter u_arbiter (
    .clk_aon   (clk_aon),
    .rst_n_i   (rst_n_i),
    .hosts     (bus_h),
    .down      (bus_d),
    .down_id_o (down_id),
    .rsp_id_i  (rsp_id)
  );

  ctn_window_decode #(
    .Latency(Latency)
  ) u_window_decode (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .up          (bus_d),
    .up_id_i     (down_id),
    .rsp_id_o    (rsp_id),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_strb_o  (ram_strb),
    .ram_rdata_i (ram_rdata)
  );

  ctn_ram #(
    .Latency(Latency)
  ) u_ram (
    .clk_aon (clk_aon),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .strb_i  (ram_strb),
    .rdata_o (ram_rdata)
  );

endmodule : ctn_fabric_top

//--- hdl/ctn_host_port.sv
/*
  Host-side entry of the fabric. Request and response pass straight through;
  new requests are held off once MaxOutstanding responses are pending.
*/
module ctn_host_port #(
  parameter int MaxOutstanding = 2
) (
  input  logic               clk_aon,
  input  logic               rst_n_i,

  input  logic               req_valid_i,
  input  logic               we_i,
  input  ctn_bus_pkg::addr_t addr_i,
  input  ctn_bus_pkg::data_t wdata_i,
  input  ctn_bus_pkg::strb_t strb_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output ctn_bus_pkg::data_t rsp_rdata_o,
  output logic               rsp_err_o,

  ctn_bus_if.host            bus
);

  localparam int CntW = $clog2(MaxOutstanding + 1);

  logic [CntW-1:0] cnt_q;
  logic            full;
  logic            accept;

  assign full   = (cnt_q == CntW'(MaxOutstanding));
  assign accept = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Request towards the arbiter
  //////////////////////////////////////////////////////////////////////

  assign bus.req_valid = req_valid_i && !full;  // Hidden from the arbiter when full
  assign bus.we        = we_i;
  assign bus.addr      = addr_i;
  assign bus.wdata     = wdata_i;
  assign bus.strb      = strb_i;
  assign req_ready_o   = bus.req_ready && !full;

  // Responses are never stalled
  assign rsp_valid_o = bus.rsp_valid;
  assign rsp_rdata_o = bus.rsp_rdata;
  assign rsp_err_o   = bus.rsp_err;

  //////////////////////////////////////////////////////////////////////
  // Pending response counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (accept && !bus.rsp_valid) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!accept && bus.rsp_valid) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Limit holds across any mix of accepts and returns
  a_cnt_limit : assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    cnt_q <= CntW'(MaxOutstanding));

  // Fabric must not return a response nobody asked for
  a_no_stray_rsp : assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    bus.rsp_valid |-> (cnt_q != '0));

endmodule : ctn_host_port

//--- hdl/ctn_mem_pkg.sv
/*
  Memory map and geometry of the CTN RAM. RamBase must be aligned to
  RamSizeBytes, and RamSizeBytes must be a power of two.
*/
package ctn_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address window
  //////////////////////////////////////////////////////////////////////

  parameter ctn_bus_pkg::addr_t RamBase = 32'h0000_1000;
  parameter int unsigned RamSizeBytes = 4096;

  //////////////////////////////////////////////////////////////////////
  // RAM geometry and timing
  //////////////////////////////////////////////////////////////////////

  parameter int RamDepth = 1024;  // 32-bit words

  typedef logic [$clog2(RamDepth)-1:0] word_addr_t;

  // Cycles from a RAM request to its read data
  parameter int RamLatency = 2;

endpackage : ctn_mem_pkg

//--- hdl/ctn_ram.sv
/*
  Single-port RAM, registered input and output, read data two cycles after
  the request. Contents power up unknown; only Latency of 2 is built.
*/
module ctn_ram #(
  parameter int Latency = 2
) (
  input  logic                    clk_aon,

  input  logic                    req_i,
  input  logic                    we_i,
  input  ctn_mem_pkg::word_addr_t addr_i,
  input  ctn_bus_pkg::data_t      wdata_i,
  input  ctn_bus_pkg::strb_t      strb_i,
  output ctn_bus_pkg::data_t      rdata_o
);

  ctn_bus_pkg::data_t mem [ctn_mem_pkg::RamDepth];

  // Input stage
  logic                    req_q;
  logic                    we_q;
  ctn_mem_pkg::word_addr_t addr_q;
  ctn_bus_pkg::data_t      wdata_q;
  ctn_bus_pkg::strb_t      strb_q;

  ctn_bus_pkg::data_t      rdata_q;  // Output stage

  //////////////////////////////////////////////////////////////////////
  // Stage 1: capture request
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    req_q   <= req_i;
    we_q    <= we_i;
    addr_q  <= addr_i;
    wdata_q <= wdata_i;
    strb_q  <= strb_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2: array access and read register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (req_q && we_q) begin
      for (int b = 0; b < $bits(ctn_bus_pkg::strb_t); b++) begin
        if (strb_q[b]) begin
          mem[addr_q][b*8 +: 8] <= wdata_q[b*8 +: 8];  // Strobed byte lane
        end
      end
    end
  end

  always_ff @(posedge clk_aon) begin
    if (req_q && !we_q) begin
      rdata_q <= mem[addr_q];
    end
  end

  assign rdata_o = rdata_q;

  // Decoder sideband depth must match the two register stages here
  a_latency : assert property (@(posedge clk_aon) Latency == 2);

endmodule : ctn_ram

//--- hdl/ctn_window_decode.sv
/*
  Address window check in front of the RAM. Every request, in window or not,
  answers exactly Latency cycles after it is seen, so responses stay in order.
*/
module ctn_window_decode #(
  parameter int Latency = 2
) (
  input  logic                       clk_aon,
  input  logic                       rst_n_i,

  ctn_bus_if.fabric                  up,
  input  ctn_bus_pkg::host_id_t      up_id_i,
  output ctn_bus_pkg::host_id_t      rsp_id_o,

  output logic                       ram_req_o,
  output logic                       ram_we_o,
  output ctn_mem_pkg::word_addr_t    ram_addr_o,
  output ctn_bus_pkg::data_t         ram_wdata_o,
  output ctn_bus_pkg::strb_t         ram_strb_o,
  input  ctn_bus_pkg::data_t         ram_rdata_i
);

  localparam ctn_bus_pkg::addr_t WinMask =
      ~ctn_bus_pkg::addr_t'(ctn_mem_pkg::RamSizeBytes - 1);
  localparam int WordLsb = 2;  // 4 bytes per word

  logic               in_win;
  ctn_bus_pkg::addr_t offset;

  // Response sideband, one entry per pipeline stage
  logic [Latency-1:0]                        vld_q;
  logic [Latency-1:0]                        err_q;
  logic [Latency-1:0]                        rd_q;   // Successful read, takes RAM data
  ctn_bus_pkg::host_id_t [Latency-1:0]       id_q;

  //////////////////////////////////////////////////////////////////////
  // Window check and RAM request
  //////////////////////////////////////////////////////////////////////

  assign in_win = (up.addr & WinMask) == ctn_mem_pkg::RamBase;
  assign offset = up.addr - ctn_mem_pkg::RamBase;

  assign up.req_ready = 1'b1;  // RAM never stalls

  assign ram_req_o   = up.req_valid && in_win;
  assign ram_we_o    = up.we;
  assign ram_addr_o  = offset[WordLsb +: $bits(ctn_mem_pkg::word_addr_t)];
  assign ram_wdata_o = up.wdata;
  assign ram_strb_o  = up.strb;

  //////////////////////////////////////////////////////////////////////
  // Sideband shift register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= up.req_valid;
      for (int i = 1; i < Latency; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_aon) begin
    err_q[0] <= !in_win;
    rd_q[0]  <= in_win && !up.we;
    id_q[0]  <= up_id_i;
    for (int i = 1; i < Latency; i++) begin
      err_q[i] <= err_q[i-1];
      rd_q[i]  <= rd_q[i-1];
      id_q[i]  <= id_q[i-1];
    end
  end

  // Errors and writes return zero data
  assign up.rsp_valid = vld_q[Latency-1];
  assign up.rsp_err   = err_q[Latency-1];
  assign up.rsp_rdata = rd_q[Latency-1] ? ram_rdata_i : '0;
  assign rsp_id_o     = id_q[Latency-1];

endmodule : ctn_window_decode

//--- run_sim.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ctn_fabric \
  -f sources.f \
  -o tb_ctn_fabric

./obj_dir/tb_ctn_fabric

//--- sources.f
hdl/ctn_bus_pkg.sv
hdl/ctn_mem_pkg.sv
hdl/ctn_bus_if.sv
hdl/ctn_host_port.sv
hdl/ctn_arbiter.sv
hdl/ctn_window_decode.sv
hdl/ctn_ram.sv
hdl/ctn_fabric_top.sv
testbench/tb_ctn_fabric.sv

//--- testbench/ctn_testdata.txt
# host we addr wdata strb, all hex, one request per line
# lines after the 'late' marker run on host 0 after every earlier response
0 1 00001000 11223344 f
1 1 00001800 a5a5a5a5 f
0 1 00001004 deadbeef f
1 1 00001804 01020304 3
0 0 00001000 00000000 0
1 0 00001800 00000000 0
0 1 00001008 cafef00d 5
1 1 00001808 0badc0de c
0 0 00001004 00000000 0
1 0 00001804 00000000 0
0 0 00001008 00000000 0
1 0 00001808 00000000 0
0 1 00002000 ffffffff f
1 1 00002800 ffffffff f
0 0 00000ffc 00000000 0
1 1 00000800 12345678 f
0 0 00002000 00000000 0
1 0 00003804 00000000 0
0 1 00001004 00ff0000 4
1 1 00001ffc 87654321 f
0 0 00001004 00000000 0
1 0 00001ffc 00000000 0
0 0 0000100c 00000000 0
1 0 00001810 00000000 0
0 1 00001010 13579bdf f
1 1 00001810 2468ace0 2
0 0 00001010 00000000 0
1 0 00001810 00000000 0
late
0 0 00001800 00000000 0
0 0 00001804 00000000 0
0 0 00001808 00000000 0
0 0 00001ffc 00000000 0
0 0 00001810 00000000 0
0 0 00001000 00000000 0

//--- testbench/tb_ctn_fabric.sv
/*
  Testbench for ctn_fabric_top. Requests come from testbench/ctn_testdata.txt,
  so the run must start in the project root. Stops at the first mismatch.
*/
module tb_ctn_fabric;

  localparam int  NumHosts    = ctn_bus_pkg::NumHosts;
  localparam int  MaxOut      = 2;
  localparam int  RspLatency  = 3;  // Fixed request-to-response cycles
  localparam time Period      = 100;
  localparam time DriveDelay  = 10;

  typedef struct {
    logic               late;  // Waits until the fabric has drained
    logic               we;
    ctn_bus_pkg::addr_t addr;
    ctn_bus_pkg::data_t wdata;
    ctn_bus_pkg::strb_t strb;
  } req_t;

  typedef struct {
    ctn_bus_pkg::data_t rdata;
    ctn_bus_pkg::data_t mask;  // Bytes that carry a known value
    logic               err;
    int                 cyc;   // Cycle count seen at acceptance
  } exp_t;

  logic clk_aon = 1'b0;
  logic rst_n_i;

  logic [NumHosts-1:0]               host_req_valid;
  logic [NumHosts-1:0]               host_we;
  ctn_bus_pkg::addr_t [NumHosts-1:0] host_addr;
  ctn_bus_pkg::data_t [NumHosts-1:0] host_wdata;
  ctn_bus_pkg::strb_t [NumHosts-1:0] host_strb;
  logic [NumHosts-1:0]               host_req_ready;
  logic [NumHosts-1:0]               host_rsp_valid;
  ctn_bus_pkg::data_t [NumHosts-1:0] host_rsp_rdata;
  logic [NumHosts-1:0]               host_rsp_err;

  req_t req_q [NumHosts][$];
  exp_t exp_q [NumHosts][$];
  ctn_bus_pkg::data_t model_mem   [int];
  ctn_bus_pkg::data_t model_known [int];

  int          idx      [NumHosts];
  int          gap      [NumHosts];
  int          wait_cnt [NumHosts];
  logic        hold     [NumHosts];
  logic        acc_seen [NumHosts];
  logic [31:0] rng;
  int          cyc;
  int          n_lines;

  ctn_fabric_top #(
    .MaxOutstanding(MaxOut)
  ) dut (
    .clk_aon          (clk_aon),
    .rst_n_i          (rst_n_i),
    .host_req_valid_i (host_req_valid),
    .host_we_i        (host_we),
    .host_addr_i      (host_addr),
    .host_wdata_i     (host_wdata),
    .host_strb_i      (host_strb),
    .host_req_ready_o (host_req_ready),
    .host_rsp_valid_o (host_rsp_valid),
    .host_rsp_rdata_o (host_rsp_rdata),
    .host_rsp_err_o   (host_rsp_err)
  );

  always #(Period / 2) clk_aon = ~clk_aon;

  always @(posedge clk_aon) begin
    cyc = cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_rdata(input string sig, input ctn_bus_pkg::data_t got,
                             input ctn_bus_pkg::data_t exp, input ctn_bus_pkg::data_t mask);
    if ((got & mask) !== (exp & mask)) begin
      $display("ERR %s got 0x%08h exp 0x%08h mask 0x%08h", sig, got, exp, mask);
      abort_run();
    end
  endtask

  task automatic check_err(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h exp 0x%0h", sig, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h exp 0x%0h", sig, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(input string sig, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s latency got 0x%0h exp 0x%0h", sig, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic in_window(input ctn_bus_pkg::addr_t a);
    return (a >= ctn_mem_pkg::RamBase) &&
           (a < ctn_mem_pkg::RamBase + ctn_mem_pkg::RamSizeBytes);
  endfunction

  task automatic load_requests();
    string       line;
    int          fd;
    logic        late;
    logic [31:0] f_host;
    logic [31:0] f_we;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_strb;
    req_t        r;
    late = 1'b0;
    fd = $fopen("testbench/ctn_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the request data file");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if (line.substr(0, 3) == "late") begin
        late = 1'b1;  // Rest of the file reads back after a drain
        continue;
      end
      if ($sscanf(line, "%h %h %h %h %h", f_host, f_we, f_addr, f_wdata, f_strb) != 5 ||
          f_host >= NumHosts || (late && f_host != 0)) begin
        $display("Malformed request line in the data file: %s", line);
        abort_run();
      end
      r.late  = late;
      r.we    = f_we[0];
      r.addr  = f_addr;
      r.wdata = f_wdata;
      r.strb  = ctn_bus_pkg::strb_t'(f_strb);
      req_q[f_host].push_back(r);
      n_lines++;
    end
    $fclose(fd);
    if (n_lines == 0) begin
      $display("The request data file holds no requests");
      abort_run();
    end
  endtask

  // Applies an accepted request to the model and queues its expected answer
  task automatic record_accept(input int h);
    exp_t e;
    int   w;
    e.cyc   = cyc;
    e.rdata = '0;
    e.mask  = '1;
    e.err   = 1'b0;
    if (!in_window(host_addr[h])) begin
      e.err = 1'b1;
    end else begin
      w = int'((host_addr[h] - ctn_mem_pkg::RamBase) >> 2);
      if (!model_mem.exists(w)) begin
        model_mem[w]   = '0;
        model_known[w] = '0;
      end
      if (host_we[h]) begin
        for (int b = 0; b < $bits(ctn_bus_pkg::strb_t); b++) begin
          if (host_strb[h][b]) begin
            model_mem[w][b*8 +: 8]   = host_wdata[h][b*8 +: 8];
            model_known[w][b*8 +: 8] = 8'hff;
          end
        end
      end else begin
        e.rdata = model_mem[w];
        e.mask  = model_known[w];  // Never-written bytes stay unchecked
      end
    end
    exp_q[h].push_back(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  task automatic monitor_host(input int h);
    exp_t e;
    int   pending;
    int   other;
    pending = exp_q[h].size();
    other   = 1 - h;
    if (pending == MaxOut && host_req_ready[h]) begin
      $display("Host %0d offered ready with %0d responses already pending", h, pending);
      abort_run();
    end
    if (host_rsp_valid[h]) begin
      if (exp_q[h].size() == 0) begin
        $display("Host %0d got a response with no request outstanding", h);
        abort_run();
      end
      e = exp_q[h].pop_front();
      check_rdata($sformatf("host_rsp_rdata_o[%0d]", h), host_rsp_rdata[h], e.rdata, e.mask);
      check_err($sformatf("host_rsp_err_o[%0d]", h), host_rsp_err[h], e.err);
      check_latency($sformatf("host_rsp_valid_o[%0d]", h), cyc - e.cyc, RspLatency);
    end
    if (host_req_valid[h] && host_req_ready[h]) begin
      record_accept(h);
      acc_seen[h] = 1'b1;
      wait_cnt[h] = 0;
    end else if (host_req_valid[h] && pending < MaxOut && host_req_ready[other]) begin
      wait_cnt[h]++;  // Lost this grant to the other host
      if (wait_cnt[h] > 1) begin
        $display("Host %0d waited through two grants to the other host", h);
        abort_run();
      end
    end
  endtask

  always @(negedge clk_aon) begin
    if (rst_n_i) begin
      for (int h = 0; h < NumHosts; h++) begin
        monitor_host(h);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drivers and run control
  //////////////////////////////////////////////////////////////////////

  function automatic logic drained();
    return idx[1] >= req_q[1].size() && !hold[1] &&
           exp_q[0].size() == 0 && exp_q[1].size() == 0;
  endfunction

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int h = 0; h < NumHosts; h++) begin
      if (hold[h] || idx[h] < req_q[h].size() || exp_q[h].size() != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic drive_host(input int h);
    req_t r;
    if (hold[h] && acc_seen[h]) begin
      hold[h]     = 1'b0;
      acc_seen[h] = 1'b0;
      idx[h]++;
      rng    = xorshift32(rng);
      gap[h] = int'(rng % 32'd3);  // 0 to 2 idle cycles
    end
    if (!hold[h]) begin
      if (gap[h] != 0) begin
        gap[h]--;
      end else if (idx[h] < req_q[h].size()) begin
        r = req_q[h][idx[h]];
        if (!r.late || drained()) begin
          host_we[h]    = r.we;
          host_addr[h]  = r.addr;
          host_wdata[h] = r.wdata;
          host_strb[h]  = r.strb;
          hold[h]       = 1'b1;
        end
      end
    end
    host_req_valid[h] = hold[h];
  endtask

  initial begin
    rst_n_i        = 1'b0;
    host_req_valid = '0;
    host_we        = '0;
    host_addr      = '0;
    host_wdata     = '0;
    host_strb      = '0;
    rng            = 32'd52;
    cyc            = 0;
    n_lines        = 0;
    for (int h = 0; h < NumHosts; h++) begin
      idx[h]      = 0;
      gap[h]      = 0;
      wait_cnt[h] = 0;
      hold[h]     = 1'b0;
      acc_seen[h] = 1'b0;
    end
    load_requests();
    repeat (3) @(posedge clk_aon);
    #DriveDelay;
    rst_n_i = 1'b1;

    // Quiet bus right after reset
    repeat (2) begin
      @(negedge clk_aon);
      for (int h = 0; h < NumHosts; h++) begin
        check_flag($sformatf("host_req_ready_o[%0d]", h), host_req_ready[h], 1'b0);
        check_flag($sformatf("host_rsp_valid_o[%0d]", h), host_rsp_valid[h], 1'b0);
      end
    end

    while (!all_done()) begin
      @(posedge clk_aon);
      #DriveDelay;
      for (int h = 0; h < NumHosts; h++) begin
        drive_host(h);
      end
    end

    $display("Test completed successfully");
    $finish;
  end

  // Watchdog scaled to the number of requests
  initial begin
    time limit;
    wait (n_lines > 0);
    limit = (n_lines * 20 + 100) * Period;
    #(limit);
    $display("Timeout: the requests did not complete in the allowed time");
    abort_run();
  end

endmodule : tb_ctn_fabric
